//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_core_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/alu_execute.sv
`timescale 1ns/10ps

module alu_execute import cpu_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  dec_exe_if.dst            de,
  exe_res_if.src            er,
  output ccr_t              ccr,
  output logic              jump_taken,
  output logic [data_w-1:0] pc_jmp
);

  logic [data_w-1:0]  res;
  logic [data_w:0]    wide;
  logic [shamt_w-1:0] shamt;
  logic               c_out, c_upd;
  logic               cond;
  ccr_t               ccr_nxt;

  assign shamt = de.op_b[shamt_w-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // alu
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    wide  = '0;
    res   = de.op_b;
    c_out = 1'b0;
    c_upd = 1'b0;
    case (de.alu_op)
      alu_add: begin
        wide  = {1'b0, de.op_a} + {1'b0, de.op_b};
        res   = wide[data_w-1:0];
        c_out = wide[data_w];
        c_upd = 1'b1;
      end
      alu_sub: begin
        wide  = {1'b0, de.op_a} - {1'b0, de.op_b};
        res   = wide[data_w-1:0];
        c_out = wide[data_w];  // borrow.
        c_upd = 1'b1;
      end
      alu_and: res = de.op_a & de.op_b;
      alu_or:  res = de.op_a | de.op_b;
      alu_xor: res = de.op_a ^ de.op_b;
      alu_not: res = ~de.op_a;
      alu_shl: begin
        wide  = {1'b0, de.op_a} << shamt;
        res   = wide[data_w-1:0];
        c_out = wide[data_w];  // last bit out the top.
        c_upd = (shamt != '0);
      end
      alu_shr: begin
        wide  = {de.op_a, 1'b0} >> shamt;
        res   = wide[data_w:1];
        c_out = wide[0];
        c_upd = (shamt != '0);
      end
      default: res = de.op_b;
    endcase
  end

  always_comb begin
    ccr_nxt = ccr;
    if (de.sets_flags) begin
      ccr_nxt.zero     = (res == '0);
      ccr_nxt.negative = res[data_w-1];
      if (c_upd) ccr_nxt.carry = c_out;
    end
  end

  // jumps see the flags from before this instruction.
  always_comb begin
    case (de.jump_kind)
      jmp_zero:  cond = ccr.zero;
      jmp_neg:   cond = ccr.negative;
      jmp_carry: cond = ccr.carry;
      default:   cond = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ccr        <= '0;
      jump_taken <= 1'b0;
      pc_jmp     <= '0;
      er.valid   <= 1'b0;
    end else begin
      er.valid   <= de.valid;
      jump_taken <= de.valid && de.is_jump && cond;
      if (de.valid) ccr <= ccr_nxt;
      if (de.valid && de.is_jump) pc_jmp <= de.op_a;
    end
  end

  always_ff @(posedge clk) begin
    if (de.valid) begin
      er.result     <= res;
      er.dst_addr   <= de.dst_addr;
      er.reg_write  <= de.reg_write;
      er.port_write <= de.port_write;
    end
  end

  a_jump_follows_valid: assert property (@(posedge clk) disable iff (!arst_n)
    jump_taken |-> $past(de.valid && de.is_jump));

endmodule

//--- logic/control_unit.sv
`timescale 1ns/10ps

module control_unit import cpu_pkg::*; (
  input  opcode_t opcode,
  output alu_op_t alu_op,
  output logic    use_imm,
  output logic    reg_write,
  output logic    sets_flags,
  output logic    is_jump,
  output jump_t   jump_kind,
  output logic    port_write
);

  always_comb begin
    alu_op     = alu_pass_b;
    use_imm    = 1'b0;
    reg_write  = 1'b0;
    sets_flags = 1'b0;
    is_jump    = 1'b0;
    jump_kind  = jump_t'(opcode[1:0]);
    port_write = 1'b0;

    case (opcode)
      op_mov: reg_write = 1'b1;
      op_add, op_sub, op_and, op_or, op_xor, op_not: begin
        reg_write  = 1'b1;
        sets_flags = 1'b1;
        case (opcode)
          op_add:  alu_op = alu_add;
          op_sub:  alu_op = alu_sub;
          op_and:  alu_op = alu_and;
          op_or:   alu_op = alu_or;
          op_xor:  alu_op = alu_xor;
          default: alu_op = alu_not;
        endcase
      end
      op_shl, op_shr: begin
        alu_op     = (opcode == op_shl) ? alu_shl : alu_shr;
        use_imm    = 1'b1;  // amount rides in op_b.
        reg_write  = 1'b1;
        sets_flags = 1'b1;
      end
      op_ldi: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      op_addi: begin
        alu_op     = alu_add;
        use_imm    = 1'b1;
        reg_write  = 1'b1;
        sets_flags = 1'b1;
      end
      op_out: port_write = 1'b1;  // rd goes out through port b.
      op_jz, op_jn, op_jc, op_jmp: is_jump = 1'b1;
      default: ;  // nop and undefined codes.
    endcase
  end

endmodule

//--- logic/cpu_core.sv
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [data_w-1:0]     instr,
  input  logic                  req,
  output logic                  ack,
  output logic                  wb_en,
  output logic [reg_addr_w-1:0] wb_addr,
  output logic [data_w-1:0]     wb_data,
  output ccr_t                  ccr,
  output logic                  jump_taken,
  output logic [data_w-1:0]     pc_jmp,
  output logic [data_w-1:0]     out_port,
  output logic                  out_valid
);

  logic done;

  dec_exe_if de_if ();
  exe_res_if er_if ();

  instr_decode i_instr_decode (
    .clk     (clk),
    .arst_n  (arst_n),
    .instr   (instr),
    .req     (req),
    .ack     (ack),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .done    (done),
    .de      (de_if.src)
  );

  alu_execute i_alu_execute (
    .clk        (clk),
    .arst_n     (arst_n),
    .de         (de_if.dst),
    .er         (er_if.src),
    .ccr        (ccr),
    .jump_taken (jump_taken),
    .pc_jmp     (pc_jmp)
  );

  result_stage i_result_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .er        (er_if.dst),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .out_port  (out_port),
    .out_valid (out_valid),
    .done      (done)
  );

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and field positions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int data_w     = 16;
  localparam int reg_addr_w = 3;
  localparam int num_regs   = 2 ** reg_addr_w;
  localparam int opcode_w   = 5;

  localparam int op_msb  = 15;
  localparam int op_lsb  = 11;
  localparam int rd_msb  = 10;  // destination and first source.
  localparam int rd_lsb  = 8;
  localparam int rb_msb  = 7;
  localparam int rb_lsb  = 5;
  localparam int imm_msb = 7;
  localparam int imm_lsb = 0;
  localparam int imm_w   = imm_msb - imm_lsb + 1;
  localparam int shamt_w = 4;   // low bits of the immediate.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [opcode_w-1:0] {
    op_nop  = 5'd0,  op_mov  = 5'd1,  op_add = 5'd2,  op_sub = 5'd3,
    op_and  = 5'd4,  op_or   = 5'd5,  op_xor = 5'd6,  op_not = 5'd7,
    op_shl  = 5'd8,  op_shr  = 5'd9,  op_ldi = 5'd10, op_addi = 5'd11,
    op_out  = 5'd12,
    op_jz   = 5'd16, op_jn   = 5'd17, op_jc  = 5'd18, op_jmp = 5'd19
  } opcode_t;

  typedef enum logic [3:0] {
    alu_pass_b, alu_add, alu_sub, alu_and, alu_or,
    alu_xor, alu_not, alu_shl, alu_shr
  } alu_op_t;

  // low two opcode bits of a jump.
  typedef enum logic [1:0] {jmp_zero, jmp_neg, jmp_carry, jmp_always} jump_t;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
  } ccr_t;

endpackage

//--- logic/instr_decode.sv
`timescale 1ns/10ps

module instr_decode import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [data_w-1:0]     instr,
  input  logic                  req,
  output logic                  ack,
  input  logic                  wb_en,
  input  logic [reg_addr_w-1:0] wb_addr,
  input  logic [data_w-1:0]     wb_data,
  input  logic                  done,
  dec_exe_if.src                de
);

  typedef enum logic [1:0] {st_idle, st_busy, st_acked} state_t;

  state_t                state;
  logic                  take;
  opcode_t               opcode;
  logic [reg_addr_w-1:0] rd, rb, rd_addr_b;
  logic [data_w-1:0]     imm_ext, rd_data_a, rd_data_b;
  alu_op_t               alu_op;
  jump_t                 jump_kind;
  logic                  use_imm, reg_write, sets_flags, is_jump, port_write;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fields and operand fetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign opcode    = opcode_t'(instr[op_msb:op_lsb]);
  assign rd        = instr[rd_msb:rd_lsb];
  assign rb        = instr[rb_msb:rb_lsb];
  assign imm_ext   = {{(data_w-imm_w){1'b0}}, instr[imm_msb:imm_lsb]};
  assign rd_addr_b = port_write ? rd : rb;  // out reads rd on port b.

  reg_file i_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr_a (rd),
    .rd_addr_b (rd_addr_b),
    .wr_en     (wb_en),
    .wr_addr   (wb_addr),
    .wr_data   (wb_data),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  control_unit i_control_unit (
    .opcode     (opcode),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .reg_write  (reg_write),
    .sets_flags (sets_flags),
    .is_jump    (is_jump),
    .jump_kind  (jump_kind),
    .port_write (port_write)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // four-phase handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign take = (state == st_idle) && req;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      ack      <= 1'b0;
      de.valid <= 1'b0;
    end else begin
      de.valid <= take;
      case (state)
        st_idle:  if (req) state <= st_busy;
        st_busy:  if (done) begin
          state <= st_acked;
          ack   <= 1'b1;
        end
        st_acked: if (!req) begin
          state <= st_idle;
          ack   <= 1'b0;
        end
        default:  state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      de.alu_op     <= alu_op;
      de.op_a       <= rd_data_a;
      de.op_b       <= use_imm ? imm_ext : rd_data_b;
      de.dst_addr   <= rd;
      de.reg_write  <= reg_write;
      de.is_jump    <= is_jump;
      de.jump_kind  <= jump_kind;
      de.port_write <= port_write;
      de.sets_flags <= sets_flags;
    end
  end

  a_valid_single: assert property (@(posedge clk) disable iff (!arst_n)
    de.valid |=> !de.valid);

  // retirement must come back from result stage first.
  a_ack_after_done: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> $past(done && state == st_busy));

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [reg_addr_w-1:0] rd_addr_a,
  input  logic [reg_addr_w-1:0] rd_addr_b,
  input  logic                  wr_en,
  input  logic [reg_addr_w-1:0] wr_addr,
  input  logic [data_w-1:0]     wr_data,
  output logic [data_w-1:0]     rd_data_a,
  output logic [data_w-1:0]     rd_data_b
);

  logic [data_w-1:0] regs [num_regs];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // reads are async.
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

//--- logic/result_stage.sv
`timescale 1ns/10ps

module result_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  exe_res_if.dst                er,
  output logic                  wb_en,
  output logic [reg_addr_w-1:0] wb_addr,
  output logic [data_w-1:0]     wb_data,
  output logic [data_w-1:0]     out_port,
  output logic                  out_valid,
  output logic                  done
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_en     <= 1'b0;
      out_valid <= 1'b0;
      done      <= 1'b0;
      out_port  <= '0;
    end else begin
      wb_en     <= er.valid && er.reg_write;
      out_valid <= er.valid && er.port_write;
      done      <= er.valid;  // every retired word, nops too.
      if (er.valid && er.port_write) out_port <= er.result;
    end
  end

  // writeback payload.
  always_ff @(posedge clk) begin
    if (er.valid) begin
      wb_addr <= er.dst_addr;
      wb_data <= er.result;
    end
  end

  a_wb_or_port: assert property (@(posedge clk) disable iff (!arst_n)
    !(wb_en && out_valid));

endmodule

//--- logic/stage_ifs.sv
`timescale 1ns/10ps

// decode to execute bundle.
interface dec_exe_if import cpu_pkg::*; ();
  logic                  valid;
  alu_op_t               alu_op;
  logic [data_w-1:0]     op_a;
  logic [data_w-1:0]     op_b;
  logic [reg_addr_w-1:0] dst_addr;
  logic                  reg_write;
  logic                  is_jump;
  jump_t                 jump_kind;
  logic                  port_write;
  logic                  sets_flags;

  modport src (output valid, alu_op, op_a, op_b, dst_addr, reg_write,
                      is_jump, jump_kind, port_write, sets_flags);
  modport dst (input  valid, alu_op, op_a, op_b, dst_addr, reg_write,
                      is_jump, jump_kind, port_write, sets_flags);
endinterface

// execute to result bundle.
interface exe_res_if import cpu_pkg::*; ();
  logic                  valid;
  logic [data_w-1:0]     result;
  logic [reg_addr_w-1:0] dst_addr;
  logic                  reg_write;
  logic                  port_write;

  modport src (output valid, result, dst_addr, reg_write, port_write);
  modport dst (input  valid, result, dst_addr, reg_write, port_write);
endinterface

//--- src.f
logic/cpu_pkg.sv
logic/stage_ifs.sv
logic/reg_file.sv
logic/control_unit.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/cpu_core.sv
tests/cpu_core_tb.sv

//--- tests/cpu_core_tb.sv
`timescale 1ns/10ps

module cpu_core_tb import cpu_pkg::*; ();

  localparam int timeout_cycles = 40;
  localparam int num_random     = 400;

  logic                  clk;
  logic                  arst_n;
  logic [data_w-1:0]     instr;
  logic                  req;
  logic                  ack;
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [data_w-1:0]     wb_data;
  ccr_t                  ccr;
  logic                  jump_taken;
  logic [data_w-1:0]     pc_jmp;
  logic [data_w-1:0]     out_port;
  logic                  out_valid;

  // reference model state.
  logic [data_w-1:0] m_regs [num_regs];
  logic              m_zero, m_neg, m_carry;
  logic [data_w-1:0] m_out, m_pc;

  // running totals kept by the monitor.
  int                    wb_total, jmp_total, out_total;
  int                    wb_at_ack;
  logic [reg_addr_w-1:0] seen_wb_addr;
  logic [data_w-1:0]     seen_wb_data, seen_out;
  logic                  prev_ack;

  cpu_core i_cpu_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr      (instr),
    .req        (req),
    .ack        (ack),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .ccr        (ccr),
    .jump_taken (jump_taken),
    .pc_jmp     (pc_jmp),
    .out_port   (out_port),
    .out_valid  (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    wb_total  = 0;
    jmp_total = 0;
    out_total = 0;
    wb_at_ack = 0;
    prev_ack  = 1'b0;
  end

  always @(negedge clk) begin
    if (arst_n) begin
      if (ack && !prev_ack) wb_at_ack = wb_total;  // writes seen before ack.
      if (wb_en) begin
        wb_total++;
        seen_wb_addr = wb_addr;
        seen_wb_data = wb_data;
      end
      if (jump_taken) jmp_total++;
      if (out_valid) begin
        out_total++;
        seen_out = out_port;
      end
      if (ack && !prev_ack && !req) abort_run("ack rose while req was low");
      if (!ack && prev_ack && req) abort_run("ack fell while req was still high");
    end
    prev_ack = ack;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic model_step(input logic [15:0] w, output int exp_wb, output int exp_jmp,
                            output int exp_out, output logic [15:0] exp_data);
    logic [4:0]  op;
    logic [15:0] a, b, imm, r;
    int          sh;
    logic        flags;
    op      = w[15:11];
    a       = m_regs[w[10:8]];
    b       = m_regs[w[7:5]];
    imm     = {8'h00, w[7:0]};
    sh      = int'(w[3:0]);
    r       = '0;
    flags   = 1'b0;
    exp_wb  = 0;
    exp_jmp = 0;
    exp_out = 0;
    case (op)
      op_mov: r = b;
      op_add: begin
        r       = a + b;
        m_carry = (r < a);  // wrapped past the top.
      end
      op_sub: begin
        r       = a - b;
        m_carry = (a < b);  // borrow.
      end
      op_and: r = a & b;
      op_or:  r = a | b;
      op_xor: r = a ^ b;
      op_not: r = ~a;
      op_shl: begin
        r = a << sh;
        if (sh != 0) m_carry = a[16 - sh];
      end
      op_shr: begin
        r = a >> sh;
        if (sh != 0) m_carry = a[sh - 1];
      end
      op_ldi: r = imm;
      op_addi: begin
        r       = a + imm;
        m_carry = (r < a);
      end
      op_out: begin
        exp_out = 1;
        m_out   = a;
      end
      op_jz, op_jn, op_jc, op_jmp: begin
        m_pc = a;
        if (op == op_jmp || (op == op_jz && m_zero) || (op == op_jn && m_neg) ||
            (op == op_jc && m_carry)) exp_jmp = 1;
      end
      default: ;  // undefined codes do nothing.
    endcase
    if (op inside {op_mov, op_add, op_sub, op_and, op_or, op_xor, op_not,
                   op_shl, op_shr, op_ldi, op_addi}) exp_wb = 1;
    flags = (exp_wb == 1) && !(op inside {op_mov, op_ldi});
    if (flags) begin
      m_zero = (r == 16'h0000);
      m_neg  = r[15];
    end
    if (exp_wb == 1) m_regs[w[10:8]] = r;
    exp_data = r;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one four-phase transfer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_instr(input logic [15:0] w);
    int          exp_wb, exp_jmp, exp_out;
    int          wb_base, jmp_base, out_base, cycles;
    logic [15:0] exp_data;
    model_step(w, exp_wb, exp_jmp, exp_out, exp_data);
    @(posedge clk);
    wb_base  = wb_total;
    jmp_base = jmp_total;
    out_base = out_total;
    instr <= w;
    req   <= 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!ack && cycles < timeout_cycles);
    if (!ack) abort_run($sformatf("timeout waiting for ack to rise, instr %h", w));
    repeat ($urandom_range(1, 4)) @(posedge clk);  // source holds req a while.
    req <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (ack && cycles < timeout_cycles);
    if (ack) abort_run($sformatf("timeout waiting for ack to fall, instr %h", w));
    @(posedge clk);
    check_eq(wb_at_ack - wb_base, exp_wb, $sformatf("wb_en pulses before ack for %h", w));
    check_eq(wb_total - wb_base, exp_wb, $sformatf("wb_en pulses for %h", w));
    if (exp_wb == 1) begin
      check_eq(seen_wb_addr, w[10:8], $sformatf("wb_addr for %h", w));
      check_eq(seen_wb_data, exp_data, $sformatf("wb_data for %h", w));
    end
    check_eq(jmp_total - jmp_base, exp_jmp, $sformatf("jump_taken pulses for %h", w));
    check_eq(out_total - out_base, exp_out, $sformatf("out_valid pulses for %h", w));
    if (exp_out == 1) check_eq(seen_out, m_out, $sformatf("out_port for %h", w));
    check_eq(ccr, {m_zero, m_neg, m_carry}, $sformatf("ccr after %h", w));
    check_eq(pc_jmp, m_pc, $sformatf("pc_jmp after %h", w));
    check_eq(out_port, m_out, $sformatf("held out_port after %h", w));
  endtask

  // mostly defined opcodes, one in sixteen undefined.
  function automatic logic [15:0] rand_instr();
    int         k;
    logic [4:0] op;
    if ($urandom_range(0, 15) == 0) begin
      k  = $urandom_range(0, 14);
      op = (k < 3) ? 5'(13 + k) : 5'(17 + k);
    end else begin
      k  = $urandom_range(0, 16);
      op = (k < 13) ? 5'(k) : 5'(k + 3);
    end
    return {op, 11'($urandom)};
  endfunction

  initial begin
    void'($urandom(19));
    arst_n = 1'b0;
    req    = 1'b0;
    instr  = '0;
    for (int i = 0; i < num_regs; i++) begin
      m_regs[i] = '0;
    end
    m_zero  = 1'b0;
    m_neg   = 1'b0;
    m_carry = 1'b0;
    m_out   = '0;
    m_pc    = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_eq(ack, 1'b0, "ack after reset");
    check_eq(wb_en, 1'b0, "wb_en after reset");
    check_eq(out_valid, 1'b0, "out_valid after reset");
    check_eq(jump_taken, 1'b0, "jump_taken after reset");
    check_eq(ccr, 3'b000, "ccr after reset");
    for (int i = 0; i < num_regs; i++) begin
      run_instr({op_out, 3'(i), 8'h00});  // registers read back zero.
    end
    for (int i = 0; i < num_regs; i++) begin
      run_instr({op_ldi, 3'(i), 8'($urandom)});
    end
    for (int n = 0; n < num_random; n++) begin
      run_instr(rand_instr());
    end
    $display("All tests passed!");
    $finish;
  end

endmodule
